// ==== Bender.yml ====
package:
  name: addressPath

sources:
  - design/addrPkg.sv
  - design/addrStageIf.sv
  - design/regAddrDecode.sv
  - design/writeAddrPipe.sv
  - design/hazardMatch.sv
  - design/exceptionVector.sv
  - design/addressPath.sv
  - target: test
    files:
      - testbench/addrChecker.sv
      - testbench/tbAddressPath.sv

// ==== all.f ====
design/addrPkg.sv
design/addrStageIf.sv
design/regAddrDecode.sv
design/writeAddrPipe.sv
design/hazardMatch.sv
design/exceptionVector.sv
design/addressPath.sv
testbench/addrChecker.sv
testbench/tbAddressPath.sv

// ==== design/addrPkg.sv ====
package addrPkg;

  // ==============================
  // Sizes
  // ==============================
  localparam int numPhysRegs  = 32;
  localparam int archRegWidth = 4;
  localparam int statusWidth  = 12;
  localparam int modeWidth    = 5;
  localparam int excWidth     = 7;

  // Architectural PC field
  localparam logic [archRegWidth-1:0] pcRegField = 4'hF;

  // Processor mode codes in status bits 4:0
  localparam logic [modeWidth-1:0] modeUsr = 5'b10000;
  localparam logic [modeWidth-1:0] modeFiq = 5'b10001;
  localparam logic [modeWidth-1:0] modeIrq = 5'b10010;
  localparam logic [modeWidth-1:0] modeSvc = 5'b10011;
  localparam logic [modeWidth-1:0] modeAbt = 5'b10111;
  localparam logic [modeWidth-1:0] modeUnd = 5'b11011;
  localparam logic [modeWidth-1:0] modeSys = 5'b11111;

  // Physical slot of banked R13 with R14 right above it
  localparam int bankBaseUsr = 13;
  localparam int bankBaseFiq = 21;
  localparam int bankBaseIrq = 23;
  localparam int bankBaseSvc = 25;
  localparam int bankBaseAbt = 27;
  localparam int bankBaseUnd = 29;

  // Fiq copies of R8..R12
  localparam int fiqLowBase = 16;

  // ==============================
  // Exceptions
  // ==============================
  localparam int excReset = 0;
  localparam int excUndef = 1;
  localparam int excSwi   = 2;
  localparam int excPabt  = 3;
  localparam int excDabt  = 4;
  localparam int excIrq   = 5;
  localparam int excFiq   = 6;

  localparam logic [31:0] vectorBase = 32'h0;
  localparam logic [31:0] vecOffReset = 32'h00;
  localparam logic [31:0] vecOffUndef = 32'h04;
  localparam logic [31:0] vecOffSwi   = 32'h08;
  localparam logic [31:0] vecOffPabt  = 32'h0C;
  localparam logic [31:0] vecOffDabt  = 32'h10;
  localparam logic [31:0] vecOffIrq   = 32'h18;
  localparam logic [31:0] vecOffFiq   = 32'h1C;

  // Instruction word as data-processing or multiply fields
  typedef union packed {
    struct packed {
      logic [3:0]              cond;
      logic [7:0]              opcode;
      logic [archRegWidth-1:0] rn;
      logic [archRegWidth-1:0] rd;
      logic [archRegWidth-1:0] rs;
      logic [3:0]              shift;
      logic [archRegWidth-1:0] rm;
    } dpFields;
    struct packed {
      logic [3:0]              cond;
      logic [7:0]              opcode;
      logic [archRegWidth-1:0] rdHi;
      logic [archRegWidth-1:0] rdLo;
      logic [archRegWidth-1:0] rs;
      logic [3:0]              mulOp;
      logic [archRegWidth-1:0] rm;
    } mulFields;
  } instrWordU;

  // Architectural field plus mode to one-hot physical select
  function automatic logic [numPhysRegs-1:0] physRegSelect(
    input logic [archRegWidth-1:0] field,
    input logic [modeWidth-1:0]    mode
  );
    logic [numPhysRegs-1:0] sel;
    int bank;
    int idx;
    // Bank for R13 and R14
    case (mode)
      modeFiq: bank = bankBaseFiq;
      modeIrq: bank = bankBaseIrq;
      modeSvc: bank = bankBaseSvc;
      modeAbt: bank = bankBaseAbt;
      modeUnd: bank = bankBaseUnd;
      // Usr, sys and undefined codes share the user bank
      default: bank = bankBaseUsr;
    endcase
    if (field < 4'd8) begin
      // R0..R7 never banked
      idx = int'(field);
    end else if (field <= 4'd12) begin
      idx = (mode == modeFiq) ? fiqLowBase + int'(field) - 8 : int'(field);
    end else if (field == pcRegField) begin
      idx = 15;
    end else begin
      // R13 at the bank base and R14 one above
      idx = bank + int'(field) - 13;
    end
    sel = '0;
    sel[idx] = 1'b1;
    return sel;
  endfunction

endpackage

// ==== design/addrStageIf.sv ====
`timescale 1ns/1ps

interface addrStageIf;

  // One-hot physical selects per stage
  logic [addrPkg::numPhysRegs-1:0] ra1D;
  logic [addrPkg::numPhysRegs-1:0] ra2D;
  logic [addrPkg::numPhysRegs-1:0] wa3D;
  logic [addrPkg::numPhysRegs-1:0] ra1E;
  logic [addrPkg::numPhysRegs-1:0] ra2E;
  logic [addrPkg::numPhysRegs-1:0] wa3E;
  logic [addrPkg::numPhysRegs-1:0] wa3M;
  logic [addrPkg::numPhysRegs-1:0] wa3W;

  // Writeback status, mode feeds back to decode
  logic [addrPkg::statusWidth-1:0] statusW;

  modport decode (output ra1D, ra2D, wa3D, input statusW);
  modport pipe (input ra1D, ra2D, wa3D, output ra1E, ra2E, wa3E, wa3M, wa3W, statusW);
  modport hazard (input ra1D, ra2D, ra1E, ra2E, wa3E, wa3M, wa3W);
  // Top level taps
  modport top (input ra1D, ra2D, wa3W);

endinterface

// ==== design/addressPath.sv ====
`timescale 1ns/1ps

module addressPath (
  input  logic                            clk,
  input  logic                            rstN,
  // Controller / datapath side
  input  logic [31:0]                     instrD,
  input  logic [31:0]                     instrE,
  input  logic [1:0]                      regSrcD,
  input  logic                            multSelectD,
  input  logic                            rsrSelectD,
  input  logic                            writeMultLoE,
  input  logic [addrPkg::statusWidth-1:0] statusE,
  input  logic [addrPkg::excWidth-1:0]    excRequestW,
  // Hazard unit controls
  input  logic                            stallE,
  input  logic                            stallM,
  input  logic                            stallW,
  input  logic                            flushW,
  // To register file
  output logic [31:0]                     ra1D,
  output logic [31:0]                     ra2D,
  output logic [31:0]                     wa3W,
  // To fetch
  output logic [31:0]                     vectorPcF,
  output logic                            exceptionSelectW,
  // To hazard unit
  output logic                            match1EM,
  output logic                            match1EW,
  output logic                            match2EM,
  output logic                            match2EW,
  output logic                            match1DE,
  output logic                            match2DE
);

  addrStageIf stage ();

  // ==============================
  // Decode
  // ==============================
  regAddrDecode uDecode (
    .instrD      (instrD),
    .regSrcD     (regSrcD),
    .multSelectD (multSelectD),
    .rsrSelectD  (rsrSelectD),
    .stage       (stage.decode)
  );

  // E, M, W stage registers
  writeAddrPipe uPipe (
    .clk          (clk),
    .rstN         (rstN),
    .instrE       (instrE),
    .writeMultLoE (writeMultLoE),
    .statusE      (statusE),
    .stallE       (stallE),
    .stallM       (stallM),
    .stallW       (stallW),
    .flushW       (flushW),
    .stage        (stage.pipe)
  );

  hazardMatch uHazard (
    .stage    (stage.hazard),
    .match1EM (match1EM),
    .match1EW (match1EW),
    .match2EM (match2EM),
    .match2EW (match2EW),
    .match1DE (match1DE),
    .match2DE (match2DE)
  );

  // Vector select near fetch
  exceptionVector uExcVec (
    .excRequestW      (excRequestW),
    .vectorPcF        (vectorPcF),
    .exceptionSelectW (exceptionSelectW)
  );

  // Register file addresses out
  assign ra1D = stage.ra1D;
  assign ra2D = stage.ra2D;
  assign wa3W = stage.wa3W;

endmodule

// ==== design/exceptionVector.sv ====
`timescale 1ns/1ps

module exceptionVector (
  input  logic [addrPkg::excWidth-1:0] excRequestW,
  output logic [31:0]                  vectorPcF,
  output logic                         exceptionSelectW
);

  assign exceptionSelectW = |excRequestW;

  // ARM priority: reset, dabt, fiq, irq, pabt, und, swi
  always_comb begin
    if (excRequestW[addrPkg::excReset]) begin
      vectorPcF = addrPkg::vectorBase + addrPkg::vecOffReset;
    end else if (excRequestW[addrPkg::excDabt]) begin
      vectorPcF = addrPkg::vectorBase + addrPkg::vecOffDabt;
    end else if (excRequestW[addrPkg::excFiq]) begin
      vectorPcF = addrPkg::vectorBase + addrPkg::vecOffFiq;
    end else if (excRequestW[addrPkg::excIrq]) begin
      vectorPcF = addrPkg::vectorBase + addrPkg::vecOffIrq;
    end else if (excRequestW[addrPkg::excPabt]) begin
      vectorPcF = addrPkg::vectorBase + addrPkg::vecOffPabt;
    end else if (excRequestW[addrPkg::excUndef]) begin
      vectorPcF = addrPkg::vectorBase + addrPkg::vecOffUndef;
    end else if (excRequestW[addrPkg::excSwi]) begin
      vectorPcF = addrPkg::vectorBase + addrPkg::vecOffSwi;
    end else begin
      // Nothing pending
      vectorPcF = '0;
    end
  end

endmodule

// ==== design/hazardMatch.sv ====
`timescale 1ns/1ps

module hazardMatch (
  addrStageIf.hazard stage,
  output logic       match1EM,
  output logic       match1EW,
  output logic       match2EM,
  output logic       match2EW,
  output logic       match1DE,
  output logic       match2DE
);

  // Overlap of one-hot selects, an all-zero stage matches nothing

  // Execute sources vs memory destination
  assign match1EM = |(stage.ra1E & stage.wa3M);
  assign match2EM = |(stage.ra2E & stage.wa3M);

  // Execute sources vs writeback destination
  assign match1EW = |(stage.ra1E & stage.wa3W);
  assign match2EW = |(stage.ra2E & stage.wa3W);

  // Decode sources vs execute destination, load-use check
  assign match1DE = |(stage.ra1D & stage.wa3E);
  assign match2DE = |(stage.ra2D & stage.wa3E);

endmodule

// ==== design/regAddrDecode.sv ====
`timescale 1ns/1ps

module regAddrDecode (
  input  logic [31:0] instrD,
  input  logic [1:0]  regSrcD,
  input  logic        multSelectD,
  input  logic        rsrSelectD,
  addrStageIf.decode  stage
);

  addrPkg::instrWordU instr;

  logic [addrPkg::archRegWidth-1:0] rnOrPcField;
  logic [addrPkg::archRegWidth-1:0] ra1Field;
  logic [addrPkg::archRegWidth-1:0] ra2Field;
  logic [addrPkg::archRegWidth-1:0] wa3Field;
  logic [addrPkg::modeWidth-1:0]    modeW;

  assign instr = instrD;

  // Banking follows the mode already committed at writeback
  assign modeW = stage.statusW[addrPkg::modeWidth-1:0];

  // ==============================
  // Field selection
  // ==============================

  // Rn, or PC for PC-relative forms
  assign rnOrPcField = regSrcD[0] ? addrPkg::pcRegField : instr.dpFields.rn;

  // Read port 1
  always_comb begin
    if (multSelectD) begin
      // Multiply reads Rm here
      ra1Field = instr.mulFields.rm;
    end else if (rsrSelectD) begin
      // Register-shifted register, Rs holds the shift amount
      ra1Field = instr.dpFields.rs;
    end else begin
      ra1Field = rnOrPcField;
    end
  end

  // Read port 2
  always_comb begin
    if (multSelectD) begin
      ra2Field = instr.mulFields.rs;
    end else if (regSrcD[1]) begin
      // Store data comes from Rd
      ra2Field = instr.dpFields.rd;
    end else begin
      ra2Field = instr.dpFields.rm;
    end
  end

  // Destination, RdHi for multiply
  assign wa3Field = multSelectD ? instr.mulFields.rdHi : instr.dpFields.rd;

  // ==============================
  // Banked mapping
  // ==============================
  assign stage.ra1D = addrPkg::physRegSelect(ra1Field, modeW);
  assign stage.ra2D = addrPkg::physRegSelect(ra2Field, modeW);
  assign stage.wa3D = addrPkg::physRegSelect(wa3Field, modeW);

endmodule

// ==== design/writeAddrPipe.sv ====
`timescale 1ns/1ps

module writeAddrPipe (
  input  logic                            clk,
  input  logic                            rstN,
  input  logic [31:0]                     instrE,
  input  logic                            writeMultLoE,
  input  logic [addrPkg::statusWidth-1:0] statusE,
  input  logic                            stallE,
  input  logic                            stallM,
  input  logic                            stallW,
  input  logic                            flushW,
  addrStageIf.pipe                        stage
);

  addrPkg::instrWordU instr;

  logic [addrPkg::numPhysRegs-1:0] wa3EQ;
  logic [addrPkg::numPhysRegs-1:0] rdLoSelE;
  logic [addrPkg::statusWidth-1:0] statusM;

  assign instr = instrE;

  // ==============================
  // Execute
  // ==============================
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      wa3EQ      <= '0;
      stage.ra1E <= '0;
      stage.ra2E <= '0;
    end else if (!stallE) begin
      wa3EQ      <= stage.wa3D;
      stage.ra1E <= stage.ra1D;
      stage.ra2E <= stage.ra2D;
    end
  end

  // Long multiply low half, mapped with the execute-stage mode
  assign rdLoSelE = addrPkg::physRegSelect(instr.mulFields.rdLo,
                                           statusE[addrPkg::modeWidth-1:0]);

  // Second write of a long multiply overrides the registered destination
  assign stage.wa3E = writeMultLoE ? rdLoSelE : wa3EQ;

  // ==============================
  // Memory
  // ==============================
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      stage.wa3M <= '0;
      statusM    <= '0;
    end else if (!stallM) begin
      stage.wa3M <= stage.wa3E;
      statusM    <= statusE;
    end
  end

  // ==============================
  // Writeback
  // ==============================
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      stage.wa3W    <= '0;
      stage.statusW <= '0;
    end else if (!stallW) begin
      if (flushW) begin
        // Bubble, no write and no hazard
        stage.wa3W    <= '0;
        stage.statusW <= '0;
      end else begin
        stage.wa3W    <= stage.wa3M;
        stage.statusW <= statusM;
      end
    end
  end

endmodule

// ==== testbench/addrChecker.sv ====
`timescale 1ns/1ps

module addrChecker (
  input  logic        clk,
  input  logic        rstN,
  input  logic        stimDone,
  input  logic [31:0] instrD,
  input  logic [31:0] instrE,
  input  logic [1:0]  regSrcD,
  input  logic        multSelectD,
  input  logic        rsrSelectD,
  input  logic        writeMultLoE,
  input  logic [11:0] statusE,
  input  logic [6:0]  excRequestW,
  input  logic        stallE,
  input  logic        stallM,
  input  logic        stallW,
  input  logic        flushW,
  input  logic [31:0] ra1D,
  input  logic [31:0] ra2D,
  input  logic [31:0] wa3W,
  input  logic [31:0] vectorPcF,
  input  logic        exceptionSelectW,
  input  logic        match1EM,
  input  logic        match1EW,
  input  logic        match2EM,
  input  logic        match2EW,
  input  logic        match1DE,
  input  logic        match2DE,
  output logic        done,
  output int          errorCount
);

  // Model stage registers
  logic [31:0] mRa1E;
  logic [31:0] mRa2E;
  logic [31:0] mWa3EQ;
  logic [31:0] mWa3M;
  logic [31:0] mWa3W;
  logic [11:0] mStatusM;
  logic [11:0] mStatusW;
  logic [31:0] expRa1D;
  logic [31:0] expRa2D;
  logic [31:0] expWa3D;
  logic [31:0] expWa3E;

  // ==============================
  // Reference rules
  // ==============================

  // Banked register map as offsets from the architectural number
  function automatic logic [31:0] bankedSelect(input logic [3:0] field, input logic [4:0] mode);
    int idx;
    idx = field;
    if (field == 4'd13 || field == 4'd14) begin
      case (mode)
        5'b10001: idx = field + 8;
        5'b10010: idx = field + 10;
        5'b10011: idx = field + 12;
        5'b10111: idx = field + 14;
        5'b11011: idx = field + 16;
        default:  idx = field;
      endcase
    end else if (field >= 4'd8 && field <= 4'd12 && mode == 5'b10001) begin
      idx = field + 8;
    end
    return 32'h1 << idx;
  endfunction

  function automatic logic [3:0] read1Field(input logic [31:0] instr, input logic [1:0] src,
                                            input logic mult, input logic rsr);
    if (mult) return instr[3:0];
    if (rsr) return instr[11:8];
    return src[0] ? 4'hF : instr[19:16];
  endfunction

  function automatic logic [3:0] read2Field(input logic [31:0] instr, input logic [1:0] src,
                                            input logic mult);
    if (mult) return instr[11:8];
    return src[1] ? instr[15:12] : instr[3:0];
  endfunction

  // Walk from lowest priority up so the highest pending cause wins
  function automatic logic [31:0] priorityVectorPc(input logic [6:0] req);
    int          order [7];
    logic [31:0] offs [7];
    logic [31:0] pc;
    order = '{0, 4, 6, 5, 3, 1, 2};
    offs  = '{32'h00, 32'h10, 32'h1C, 32'h18, 32'h0C, 32'h04, 32'h08};
    pc    = 32'h0;
    for (int k = 6; k >= 0; k--) begin
      if (req[order[k]]) pc = addrPkg::vectorBase + offs[k];
    end
    return pc;
  endfunction

  assign expRa1D = bankedSelect(read1Field(instrD, regSrcD, multSelectD, rsrSelectD),
                                mStatusW[4:0]);
  assign expRa2D = bankedSelect(read2Field(instrD, regSrcD, multSelectD), mStatusW[4:0]);
  assign expWa3D = bankedSelect(multSelectD ? instrD[19:16] : instrD[15:12], mStatusW[4:0]);
  // RdLo of a long multiply in the execute-stage mode
  assign expWa3E = writeMultLoE ? bankedSelect(instrE[15:12], statusE[4:0]) : mWa3EQ;

  // Model pipeline from the inputs seen before each edge
  always @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      mRa1E    <= '0;
      mRa2E    <= '0;
      mWa3EQ   <= '0;
      mWa3M    <= '0;
      mWa3W    <= '0;
      mStatusM <= '0;
      mStatusW <= '0;
    end else begin
      if (!stallE) begin
        mRa1E  <= expRa1D;
        mRa2E  <= expRa2D;
        mWa3EQ <= expWa3D;
      end
      if (!stallM) begin
        mWa3M    <= expWa3E;
        mStatusM <= statusE;
      end
      if (!stallW) begin
        mWa3W    <= flushW ? '0 : mWa3M;
        mStatusW <= flushW ? '0 : mStatusM;
      end
    end
  end

  task automatic compareSignal(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
    if (actual !== expected) begin
      errorCount++;
      $display("Fail time=%0t signal=%s expected=%h dut=%h", $time, name, expected, actual);
    end
  endtask

  initial begin
    errorCount = 0;
    done = 1'b0;
  end

  // ==============================
  // Compare at the falling edge
  // ==============================
  always @(negedge clk) begin
    compareSignal("ra1D", expRa1D, ra1D);
    compareSignal("ra2D", expRa2D, ra2D);
    compareSignal("wa3W", mWa3W, wa3W);
    compareSignal("match1EM", |(mRa1E & mWa3M), match1EM);
    compareSignal("match2EM", |(mRa2E & mWa3M), match2EM);
    compareSignal("match1EW", |(mRa1E & mWa3W), match1EW);
    compareSignal("match2EW", |(mRa2E & mWa3W), match2EW);
    compareSignal("match1DE", |(expRa1D & expWa3E), match1DE);
    compareSignal("match2DE", |(expRa2D & expWa3E), match2DE);
    compareSignal("vectorPcF", priorityVectorPc(excRequestW), vectorPcF);
    compareSignal("exceptionSelectW", excRequestW != 7'h0, exceptionSelectW);
    if (stimDone) done <= 1'b1;
  end

endmodule

// ==== testbench/tbAddressPath.sv ====
`timescale 1ns/1ps

module tbAddressPath;

  logic        clk = 1'b0;
  logic        rstN;
  logic [31:0] instrD;
  logic [31:0] instrE;
  logic [1:0]  regSrcD;
  logic        multSelectD;
  logic        rsrSelectD;
  logic        writeMultLoE;
  logic [11:0] statusE;
  logic [6:0]  excRequestW;
  logic        stallE;
  logic        stallM;
  logic        stallW;
  logic        flushW;
  logic [31:0] ra1D;
  logic [31:0] ra2D;
  logic [31:0] wa3W;
  logic [31:0] vectorPcF;
  logic        exceptionSelectW;
  logic        match1EM;
  logic        match1EW;
  logic        match2EM;
  logic        match2EW;
  logic        match1DE;
  logic        match2DE;
  logic        stimDone;
  logic        done;
  int          errorCount;
  int          timeoutCount;
  int          waitCycles;
  logic [31:0] rngState;
  logic [4:0]  legalModes [7];

  addressPath DUT (.*);

  // Scoreboard watching every DUT port
  addrChecker uChecker (.*);

  // 4 ns clock
  always #2 clk = ~clk;

  function automatic logic [31:0] xorshift(input logic [31:0] state);
    logic [31:0] x;
    x = state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic nextRandom(output logic [31:0] value);
    rngState = xorshift(rngState);
    value = rngState;
  endtask

  // ==============================
  // One cycle of random stimulus
  // ==============================
  task automatic driveCycle();
    logic [31:0] r0;
    logic [31:0] r1;
    logic [31:0] r2;
    logic [31:0] r3;
    logic [11:0] status;
    nextRandom(r0);
    nextRandom(r1);
    nextRandom(r2);
    nextRandom(r3);
    // Mostly legal mode codes and one draw in eight arbitrary
    status[11:5] = r2[15:9];
    status[4:0]  = (r2[18:16] != 3'd7) ? legalModes[r2[18:16]] : r2[23:19];
    instrD       <= r0;
    instrE       <= r1;
    regSrcD      <= r2[1:0];
    multSelectD  <= r2[2];
    rsrSelectD   <= r2[3];
    writeMultLoE <= (r2[5:4] == 2'b00);
    statusE      <= status;
    // Rare stalls and slightly more frequent flushes
    stallE       <= (r3[3:0] == 4'h0);
    stallM       <= (r3[7:4] == 4'h0);
    stallW       <= (r3[11:8] == 4'h0);
    flushW       <= (r3[14:12] == 3'h0);
    // Multi-bit exception requests a quarter of the time
    excRequestW  <= (r3[16:15] == 2'b00) ? r3[23:17] : 7'h0;
  endtask

  initial begin
    rstN         = 1'b0;
    instrD       = '0;
    instrE       = '0;
    regSrcD      = '0;
    multSelectD  = 1'b0;
    rsrSelectD   = 1'b0;
    writeMultLoE = 1'b0;
    statusE      = '0;
    excRequestW  = '0;
    stallE       = 1'b0;
    stallM       = 1'b0;
    stallW       = 1'b0;
    flushW       = 1'b0;
    stimDone     = 1'b0;
    timeoutCount = 0;
    rngState     = 32'h9898;
    legalModes   = '{addrPkg::modeUsr, addrPkg::modeFiq, addrPkg::modeIrq,
                     addrPkg::modeSvc, addrPkg::modeAbt, addrPkg::modeUnd,
                     addrPkg::modeSys};

    // Idle inputs through reset
    repeat (8) @(posedge clk);
    rstN <= 1'b1;

    for (int i = 0; i < 3000; i++) begin
      @(posedge clk);
      driveCycle();
    end
    @(posedge clk);
    stimDone <= 1'b1;

    // Checker finishes its last compare
    waitCycles = 0;
    while (!done && waitCycles < 50) begin
      @(posedge clk);
      waitCycles++;
    end
    if (!done) begin
      $display("Checker never reported done after 50 cycles");
      timeoutCount++;
    end

    $display("Errors: %0d, timeouts: %0d", errorCount, timeoutCount);
    if (errorCount == 0 && timeoutCount == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule
